// ==== rv_trap_pkg.sv ====
package rv_trap_pkg;

	// synchronous trap flags carried down the pipe
	typedef struct packed {
		logic instr_misaligned;
		logic illegal_instr;
		logic ecall;
		logic ebreak;
		logic mret;
		logic sret;
		logic uret;
	} trap_flags_t;

	// per-mode timer and external enables, machine first
	typedef struct packed {
		logic m_tie;
		logic m_eie;
		logic s_tie;
		logic s_eie;
		logic u_tie;
		logic u_eie;
	} trap_enable_t;

	typedef logic [31:0] cause_t;

	localparam cause_t cause_int = 32'h8000_0000;	// interrupt marker bit

	// exception codes
	localparam cause_t exc_instr_misaligned = 32'h0;
	localparam cause_t exc_illegal_instr    = 32'h2;
	localparam cause_t exc_breakpoint       = 32'h3;
	localparam cause_t exc_u_call           = 32'h8;
	localparam cause_t exc_s_call           = 32'h9;
	localparam cause_t exc_m_call           = 32'hb;

	// interrupt codes, or'ed with cause_int
	localparam cause_t int_u_timer = 32'h4;
	localparam cause_t int_s_timer = 32'h5;
	localparam cause_t int_m_timer = 32'h7;
	localparam cause_t int_u_ext   = 32'h8;
	localparam cause_t int_s_ext   = 32'h9;
	localparam cause_t int_m_ext   = 32'hb;

endpackage

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// {funct7[5], funct3}
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111,
		alu_sub  = 4'b1000,
		alu_sra  = 4'b1101
	} alu_op_t;

	typedef enum logic [2:0] {
		wb_alu   = 3'd0,
		wb_link  = 3'd1,	// pc + 4
		wb_lui   = 3'd3,
		wb_auipc = 3'd5
	} wb_sel_t;

	typedef enum logic [1:0] {
		priv_u = 2'b00,
		priv_s = 2'b01,
		priv_m = 2'b11
	} priv_mode_t;

	// stage 5 contents
	typedef struct packed {
		word_t op_a;
		word_t op_b;
		word_t pc;
		word_t b_imm;
		word_t j_imm;
		word_t u_imm;
		alu_op_t alu_op;
		wb_sel_t wb_sel;
		logic we;
		reg_addr_t rd;
		logic btype;
		logic bneq;
		logic j;
		logic jr;
		rv_trap_pkg::trap_flags_t flags;
	} ex_payload_t;

	// stage 6 contents
	typedef struct packed {
		word_t result;
		word_t pc;
		word_t u_imm;
		word_t auipc;	// pc + u_imm, formed in stage 5
		wb_sel_t wb_sel;
		logic we;
		reg_addr_t rd;
		rv_trap_pkg::trap_flags_t flags;
	} wb_payload_t;

endpackage

// ==== trap_if.sv ====
`timescale 1ns/10ps

interface trap_if import rv_isa_pkg::*, rv_trap_pkg::*; ();

	trap_flags_t flags;	// stage 6 synchronous flags
	priv_mode_t mode;

	logic exception;
	cause_t cause;
	logic m_int;
	logic s_int;
	logic u_int;

	// pipeline side
	modport pipe (
		output flags,
		output mode,
		input exception,
		input cause,
		input m_int,
		input s_int,
		input u_int
	);

	// trap decision side
	modport trap (
		input flags,
		input mode,
		output exception,
		output cause,
		output m_int,
		output s_int,
		output u_int
	);

endinterface

// ==== stage_reg.sv ====
`timescale 1ns/10ps

module stage_reg import rv_isa_pkg::*; #(
	parameter type payload_t = wb_payload_t
) (
	input logic clk,
	input logic nrst,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			q <= '0;
		else if (flush)
		begin
			q <= '0;		// bubble
			q.pc <= q.pc;	// trap_pc must survive the flush
		end
		else
			q <= d;
	end

endmodule

// ==== alu_branch.sv ====
`timescale 1ns/10ps

module alu_branch import rv_isa_pkg::*; (
	input ex_payload_t ex,
	output word_t result,
	output logic redirect,
	output word_t target
);

	logic [4:0] shamt;
	logic cond;
	logic taken;
	word_t jr_sum;

	assign shamt = ex.op_b[4:0];

	always_comb
	begin
		case (ex.alu_op)
			alu_add:  result = ex.op_a + ex.op_b;
			alu_sub:  result = ex.op_a - ex.op_b;
			alu_sll:  result = ex.op_a << shamt;
			alu_slt:  result = {{(xlen-1){1'b0}}, $signed(ex.op_a) < $signed(ex.op_b)};
			alu_sltu: result = {{(xlen-1){1'b0}}, ex.op_a < ex.op_b};
			alu_xor:  result = ex.op_a ^ ex.op_b;
			alu_srl:  result = ex.op_a >> shamt;
			alu_sra:  result = $unsigned($signed(ex.op_a) >>> shamt);
			alu_or:   result = ex.op_a | ex.op_b;
			alu_and:  result = ex.op_a & ex.op_b;
			default:  result = '0;
		endcase
	end

	// beq/bne use sub, blt/bge/bltu/bgeu use the set-less-than ops
	always_comb
	begin
		cond = 1'b0;
		if (ex.alu_op == alu_sub)
			cond = (result == '0);
		else if (ex.alu_op == alu_slt || ex.alu_op == alu_sltu)
			cond = result[0];
	end

	assign taken = ex.btype & (cond ^ ex.bneq);	// bneq flips ne/ge forms
	assign redirect = taken | ex.j | ex.jr;

	assign jr_sum = ex.op_a + ex.op_b;

	always_comb
	begin
		if (ex.jr)
			target = {jr_sum[xlen-1:1], 1'b0};	// jalr clears bit 0
		else if (ex.j)
			target = ex.pc + ex.j_imm;
		else
			target = ex.pc + ex.b_imm;
	end

endmodule

// ==== trap_enable_regs.sv ====
`timescale 1ns/10ps

module trap_enable_regs import rv_trap_pkg::*; (
	input logic clk,
	input logic nrst,
	input logic cfg_req,
	input trap_enable_t cfg_wdata,
	output logic cfg_ack,
	output trap_enable_t enables
);

	// four-phase write: req up, ack up, req down, ack down
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			cfg_ack <= 1'b0;
			enables <= '0;	// all interrupts masked
		end
		else if (cfg_req && !cfg_ack)
		begin
			enables <= cfg_wdata;	// exactly one store per handshake
			cfg_ack <= 1'b1;
		end
		else if (!cfg_req)
			cfg_ack <= 1'b0;
	end

endmodule

// ==== trap_unit.sv ====
`timescale 1ns/10ps

module trap_unit import rv_isa_pkg::*, rv_trap_pkg::*; (
	trap_if.trap trap,
	input trap_enable_t enables,
	input logic m_timer,
	input logic s_timer,
	input logic u_timer,
	input logic external_interrupt
);

	logic s_ok;
	logic u_ok;
	logic m_tmr;
	logic m_ext;
	logic s_tmr;
	logic s_ext;
	logic u_tmr;
	logic u_ext;

	// lower-privilege interrupts are masked while running above them
	assign s_ok = (trap.mode != priv_m);
	assign u_ok = (trap.mode == priv_u);

	assign m_tmr = enables.m_tie & m_timer;
	assign m_ext = enables.m_eie & external_interrupt;
	assign s_tmr = s_ok & enables.s_tie & s_timer;
	assign s_ext = s_ok & enables.s_eie & external_interrupt;
	assign u_tmr = u_ok & enables.u_tie & u_timer;
	assign u_ext = u_ok & enables.u_eie & external_interrupt;

	// one line per privilege level, timer or external
	assign trap.m_int = m_tmr | m_ext;
	assign trap.s_int = s_tmr | s_ext;
	assign trap.u_int = u_tmr | u_ext;

	// xret flags are in here too, they commit through the trap path
	assign trap.exception = trap.m_int | trap.s_int | trap.u_int | (|trap.flags);

	always_comb
	begin
		if (m_ext)
			trap.cause = cause_int | int_m_ext;
		else if (s_ext)
			trap.cause = cause_int | int_s_ext;
		else if (m_tmr)
			trap.cause = cause_int | int_m_timer;
		else if (s_tmr)
			trap.cause = cause_int | int_s_timer;
		else if (u_ext)
			trap.cause = cause_int | int_u_ext;
		else if (u_tmr)
			trap.cause = cause_int | int_u_timer;
		else if (trap.flags.instr_misaligned)
			trap.cause = exc_instr_misaligned;
		else if (trap.flags.illegal_instr)
			trap.cause = exc_illegal_instr;
		else if (trap.flags.ecall)
		begin
			case (trap.mode)	// code depends on where the call came from
				priv_u:  trap.cause = exc_u_call;
				priv_s:  trap.cause = exc_s_call;
				default: trap.cause = exc_m_call;
			endcase
		end
		else if (trap.flags.ebreak)
			trap.cause = exc_breakpoint;
		else
			trap.cause = '0;	// nothing, or an xret
	end

endmodule

// ==== exe_core.sv ====
`timescale 1ns/10ps

module exe_core import rv_isa_pkg::*, rv_trap_pkg::*; (
	input logic clk,
	input logic nrst,
	input word_t op_a,
	input word_t op_b,
	input word_t pc,
	input word_t b_imm,
	input word_t j_imm,
	input word_t u_imm,
	input alu_op_t alu_op,
	input wb_sel_t wb_sel,
	input logic we,
	input reg_addr_t rd,
	input logic btype,
	input logic bneq,
	input logic j,
	input logic jr,
	input logic instr_misaligned,
	input logic illegal_instr,
	input logic ecall,
	input logic ebreak,
	input logic mret,
	input logic sret,
	input logic uret,
	input priv_mode_t current_mode,
	input logic m_timer,
	input logic s_timer,
	input logic u_timer,
	input logic external_interrupt,
	input logic cfg_req,
	input trap_enable_t cfg_wdata,
	output logic cfg_ack,
	output trap_enable_t cfg_enables,
	output logic redirect,
	output word_t target,
	output word_t wb_data,
	output logic wb_we,
	output reg_addr_t wb_rd,
	output logic exception,
	output cause_t cause,
	output word_t trap_pc,
	output logic mret_commit,
	output logic sret_commit,
	output logic uret_commit,
	output logic m_interrupt,
	output logic s_interrupt,
	output logic u_interrupt
);

	ex_payload_t ex_d;
	ex_payload_t ex_q;
	wb_payload_t wb_d;
	wb_payload_t wb_q;
	word_t alu_res;

	trap_if tif ();

	always_comb
	begin
		ex_d.op_a = op_a;
		ex_d.op_b = op_b;
		ex_d.pc = pc;
		ex_d.b_imm = b_imm;
		ex_d.j_imm = j_imm;
		ex_d.u_imm = u_imm;
		ex_d.alu_op = alu_op;
		ex_d.wb_sel = wb_sel;
		ex_d.we = we;
		ex_d.rd = rd;
		ex_d.btype = btype;
		ex_d.bneq = bneq;
		ex_d.j = j;
		ex_d.jr = jr;
		ex_d.flags = '{instr_misaligned, illegal_instr, ecall, ebreak, mret, sret, uret};
	end

	stage_reg #(.payload_t(ex_payload_t)) ex_stage (
		.clk(clk),
		.nrst(nrst),
		.flush(tif.exception),
		.d(ex_d),
		.q(ex_q)
	);

	alu_branch u_alu_branch (
		.ex(ex_q),
		.result(alu_res),
		.redirect(redirect),
		.target(target)
	);

	always_comb
	begin
		wb_d.result = alu_res;
		wb_d.pc = ex_q.pc;
		wb_d.u_imm = ex_q.u_imm;
		wb_d.auipc = ex_q.pc + ex_q.u_imm;
		wb_d.wb_sel = ex_q.wb_sel;
		wb_d.we = ex_q.we;
		wb_d.rd = ex_q.rd;
		wb_d.flags = ex_q.flags;
	end

	stage_reg #(.payload_t(wb_payload_t)) wb_stage (
		.clk(clk),
		.nrst(nrst),
		.flush(tif.exception),
		.d(wb_d),
		.q(wb_q)
	);

	// stage 6 view for the trap logic
	assign tif.flags = wb_q.flags;
	assign tif.mode = current_mode;

	trap_enable_regs u_trap_enable_regs (
		.clk(clk),
		.nrst(nrst),
		.cfg_req(cfg_req),
		.cfg_wdata(cfg_wdata),
		.cfg_ack(cfg_ack),
		.enables(cfg_enables)
	);

	trap_unit u_trap_unit (
		.trap(tif.trap),
		.enables(cfg_enables),
		.m_timer(m_timer),
		.s_timer(s_timer),
		.u_timer(u_timer),
		.external_interrupt(external_interrupt)
	);

	always_comb
	begin
		case (wb_q.wb_sel)
			wb_alu:   wb_data = wb_q.result;
			wb_link:  wb_data = wb_q.pc + 32'd4;
			wb_lui:   wb_data = wb_q.u_imm;
			wb_auipc: wb_data = wb_q.auipc;
			default:  wb_data = '0;
		endcase
	end

	assign wb_we = wb_q.we & ~tif.exception;	// trapping instr never writes
	assign wb_rd = wb_q.rd;

	assign exception = tif.exception;
	assign cause = tif.cause;
	assign trap_pc = wb_q.pc;

	assign mret_commit = wb_q.flags.mret;
	assign sret_commit = wb_q.flags.sret;
	assign uret_commit = wb_q.flags.uret;

	assign m_interrupt = tif.m_int;
	assign s_interrupt = tif.s_int;
	assign u_interrupt = tif.u_int;

endmodule

// ==== exe_core_properties.sv ====
`timescale 1ns/10ps

module exe_core_properties import rv_isa_pkg::*, rv_trap_pkg::*; (
	input logic clk,
	input logic nrst,
	input logic cfg_req,
	input logic cfg_ack,
	input logic exception,
	input logic wb_we,
	input word_t trap_pc,
	input cause_t cause
);

	ack_needs_req: assert property (@(posedge clk) disable iff (!nrst)
		$rose(cfg_ack) |-> $past(cfg_req))
		else $error("cfg_ack rose without a pending request");

	// ack only drops once req has gone
	ack_holds: assert property (@(posedge clk) disable iff (!nrst)
		cfg_ack && cfg_req |=> cfg_ack)
		else $error("cfg_ack dropped while cfg_req still high");

	// flushed stage 6 slot is a bubble
	no_write_on_trap: assert property (@(posedge clk) disable iff (!nrst)
		exception |=> !wb_we)
		else $error("wb_we high in the cycle after an exception");

	trap_pc_held: assert property (@(posedge clk) disable iff (!nrst)
		exception |=> $stable(trap_pc))
		else $error("trap_pc changed across a flush");

	cause_needs_exception: assert property (@(posedge clk) disable iff (!nrst)
		!exception |-> cause == '0)
		else $error("nonzero cause without an exception");

endmodule

bind exe_core exe_core_properties props (
	.clk(clk),
	.nrst(nrst),
	.cfg_req(cfg_req),
	.cfg_ack(cfg_ack),
	.exception(exception),
	.wb_we(wb_we),
	.trap_pc(trap_pc),
	.cause(cause)
);

// ==== exe_core_tb.sv ====
`timescale 1ns/10ps

module exe_core_tb import rv_isa_pkg::*, rv_trap_pkg::*; ();

	typedef struct packed {
		int due;
		logic redir;
		word_t target;
	} redir_exp_t;

	typedef struct packed {
		int due;
		word_t data;
		logic [4:0] rd;
		logic [8:0] status;	// redir, we, exc, m/s/u ret, m/s/u int
		word_t cause;
		word_t pc;
	} wb_exp_t;

	logic clk = 1'b0;
	logic nrst;
	word_t op_a, op_b, pc, b_imm, j_imm, u_imm;
	alu_op_t alu_op;
	wb_sel_t wb_sel;
	logic we, btype, bneq, j, jr;
	reg_addr_t rd;
	logic instr_misaligned, illegal_instr, ecall, ebreak, mret, sret, uret;
	priv_mode_t current_mode;
	logic m_timer, s_timer, u_timer, external_interrupt;
	logic cfg_req;
	trap_enable_t cfg_wdata;
	logic cfg_ack;
	trap_enable_t cfg_enables;
	logic redirect;
	word_t target, wb_data, trap_pc;
	logic wb_we, exception;
	reg_addr_t wb_rd;
	cause_t cause;
	logic mret_commit, sret_commit, uret_commit;
	logic m_interrupt, s_interrupt, u_interrupt;

	string lines[$];
	redir_exp_t redir_q[$];
	wb_exp_t wb_q[$];
	int cyc = 0;	// negedges seen by the checker
	int dcyc = 0;	// negedges seen by the driver
	int limit = 0;

	exe_core dut (.*);

	always #4 clk = ~clk;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic compare(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got %h expected %h", name, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic next_cycle;
		@(negedge clk);
		dcyc++;
	endtask

	task automatic clear_instr;
		{op_a, op_b, pc, b_imm, j_imm, u_imm} <= '0;
		alu_op <= alu_add;
		wb_sel <= wb_alu;
		{we, rd, btype, bneq, j, jr} <= '0;
		{instr_misaligned, illegal_instr, ecall, ebreak, mret, sret, uret} <= '0;
	endtask

	task automatic drive_mode_ints(input logic [31:0] mode, input logic [31:0] ints);
		current_mode <= priv_mode_t'(mode[1:0]);
		{m_timer, s_timer, u_timer, external_interrupt} <= ints[3:0];
	endtask

	task automatic config_write(input logic [31:0] v);
		int n;
		clear_instr();
		cfg_wdata <= trap_enable_t'(v[5:0]);
		cfg_req <= 1'b1;
		n = 0;
		do
		begin
			next_cycle();
			n++;
		end while (!cfg_ack && n < 8);
		if (!cfg_ack)
			stop_with_error("config write never got an acknowledge");
		cfg_req <= 1'b0;
		n = 0;
		do
		begin
			next_cycle();
			n++;
		end while (cfg_ack && n < 8);
		if (cfg_ack)
			stop_with_error("acknowledge stayed high after the request dropped");
		compare("cfg_enables", 32'(cfg_enables), {26'b0, v[5:0]});
	endtask

	// redirect one negedge after issue, stage 6 two negedges after
	always @(negedge clk)
	begin
		cyc++;
		if (limit != 0 && cyc > limit)
			stop_with_error("timeout, the tests did not finish within the cycle limit");
		while (redir_q.size() != 0 && redir_q[0].due == cyc)
		begin
			compare("redirect", 32'(redirect), 32'(redir_q[0].redir));
			if (redir_q[0].redir)
				compare("target", target, redir_q[0].target);
			void'(redir_q.pop_front());
		end
		while (wb_q.size() != 0 && wb_q[0].due == cyc)
		begin
			compare("wb_we", 32'(wb_we), 32'(wb_q[0].status[7]));
			compare("exception", 32'(exception), 32'(wb_q[0].status[6]));
			compare("cause", cause, wb_q[0].cause);
			compare("trap_pc", trap_pc, wb_q[0].pc);
			compare("xret_commit", 32'({mret_commit, sret_commit, uret_commit}),
				32'(wb_q[0].status[5:3]));
			compare("interrupt", 32'({m_interrupt, s_interrupt, u_interrupt}),
				32'(wb_q[0].status[2:0]));
			if (wb_q[0].status[7])
			begin
				compare("wb_data", wb_data, wb_q[0].data);
				compare("wb_rd", 32'(wb_rd), 32'(wb_q[0].rd));
			end
			void'(wb_q.pop_front());
		end
	end

	initial
	begin
		int fd;
		int cnt;
		string line;
		logic [31:0] f [16];
		redir_exp_t rexp;
		wb_exp_t wexp;
		nrst = 1'b0;
		clear_instr();
		drive_mode_ints(32'h3, 32'h0);
		cfg_req <= 1'b0;
		cfg_wdata <= '0;
		fd = $fopen("exe_tests.txt", "r");
		if (fd == 0)
			stop_with_error("cannot open exe_tests.txt");
		while (!$feof(fd))
		begin
			if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#")
				lines.push_back(line);
		end
		$fclose(fd);
		limit = 4 * lines.size() + 20;
		repeat (3) next_cycle();
		nrst <= 1'b1;
		foreach (lines[i])
		begin
			next_cycle();
			line = lines[i];
			if (line.getc(0) == "I")
			begin
				cnt = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
					f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
				if (cnt != 16)
					stop_with_error("malformed instruction line in exe_tests.txt");
				op_a <= f[0];
				op_b <= f[1];
				pc <= f[2];
				b_imm <= f[3];
				j_imm <= f[4];
				u_imm <= f[5];
				alu_op <= alu_op_t'(f[6][16:13]);
				wb_sel <= wb_sel_t'(f[6][12:10]);
				{we, rd, btype, bneq, j, jr} <= f[6][9:0];
				{instr_misaligned, illegal_instr, ecall, ebreak, mret, sret, uret} <= f[7][6:0];
				drive_mode_ints(f[8], f[9]);
				rexp.due = dcyc + 1;
				rexp.redir = f[13][8];
				rexp.target = f[10];
				redir_q.push_back(rexp);
				wexp.due = dcyc + 2;
				wexp.data = f[11];
				wexp.rd = f[12][4:0];
				wexp.status = f[13][8:0];
				wexp.cause = f[14];
				wexp.pc = f[15];
				wb_q.push_back(wexp);
			end
			else if (line.getc(0) == "C")
			begin
				if ($sscanf(line, "C %h", f[0]) != 1)
					stop_with_error("malformed config line in exe_tests.txt");
				config_write(f[0]);
			end
			else if (line.getc(0) == "N")
			begin
				if ($sscanf(line, "N %h %h", f[0], f[1]) != 2)
					stop_with_error("malformed idle line in exe_tests.txt");
				clear_instr();
				drive_mode_ints(f[0], f[1]);
			end
			else
				stop_with_error("unknown line type in exe_tests.txt");
		end
		while (redir_q.size() != 0 || wb_q.size() != 0)
			next_cycle();
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== exe_core.f ====
rv_trap_pkg.sv
rv_isa_pkg.sv
trap_if.sv
stage_reg.sv
alu_branch.sv
trap_enable_regs.sv
trap_unit.sv
exe_core.sv
exe_core_properties.sv
exe_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= exe_core_tb
FILELIST ?= exe_core.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
		echo "simulation did not pass, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== exe_tests.txt ====
# I op_a op_b pc b_imm j_imm u_imm ctl flags mode ints target wb_data rd status cause trap_pc
# ctl={alu_op,wb_sel,we,rd,btype,bneq,j,jr} status={redir,we,exc,mret,sret,uret,m,s,u int}; C en; N mode ints
I 5 3 100 0 0 0 210 0 3 0 0 8 1 80 0 100
I 5 7 104 0 0 0 10220 0 3 0 0 fffffffe 2 80 0 104
I 1 4 108 0 0 0 2230 0 3 0 0 10 3 80 0 108
I ffffffff 1 10c 0 0 0 4240 0 3 0 0 1 4 80 0 10c
I ffffffff 1 110 0 0 0 6250 0 3 0 0 0 5 80 0 110
I f0f0 ff00 114 0 0 0 8260 0 3 0 0 ff0 6 80 0 114
I 80000000 4 118 0 0 0 a270 0 3 0 0 8000000 7 80 0 118
I 80000000 4 11c 0 0 0 1a280 0 3 0 0 f8000000 8 80 0 11c
I f0 f 120 0 0 0 c290 0 3 0 0 ff 9 80 0 120
I f0 3c 124 0 0 0 e2a0 0 3 0 0 30 a 80 0 124
I 0 0 128 0 0 0 6b0 0 3 0 0 12c b 80 0 128
I 0 0 12c 0 0 12345000 ec0 0 3 0 0 12345000 c 80 0 12c
I 0 0 130 0 0 1000 16d0 0 3 0 0 1130 d 80 0 130
I 7 7 200 10 0 0 10008 0 3 0 210 0 0 100 0 200
I 7 7 204 10 0 0 1000c 0 3 0 0 0 0 0 0 204
I fffffffe 1 208 fffffff8 0 0 4008 0 3 0 200 0 0 100 0 208
I fffffffe 1 20c 8 0 0 400c 0 3 0 0 0 0 0 0 20c
I fffffffe 1 210 8 0 0 6008 0 3 0 0 0 0 0 0 210
I fffffffe 1 214 20 0 0 600c 0 3 0 234 0 0 100 0 214
I 0 0 300 0 100 0 612 0 3 0 400 304 1 180 0 300
I 1001 4 304 0 0 0 611 0 3 0 1004 308 1 180 0 304
I 0 0 400 0 0 0 210 10 0 0 0 0 1 40 8 400
I 1 1 404 0 0 0 210 0 0 0 0 0 1 0 0 400
N 0 0
I 0 0 408 0 0 0 210 10 1 0 0 0 1 40 9 408
N 1 0
N 1 0
I 0 0 410 0 0 0 210 10 3 0 0 0 1 40 b 410
N 3 0
N 3 0
I 0 0 418 0 0 0 210 8 3 0 0 0 1 40 3 418
N 3 0
N 3 0
I 0 0 420 0 0 0 210 20 3 0 0 0 1 40 2 420
N 3 0
N 3 0
I 0 0 428 0 0 0 210 38 3 0 0 0 1 40 2 428
N 3 0
N 3 0
I 0 0 430 0 0 0 210 60 3 0 0 0 1 40 0 430
N 3 0
N 3 0
I 0 0 438 0 0 0 210 4 3 0 0 0 1 60 0 438
N 3 0
N 3 0
I 0 0 440 0 0 0 210 2 3 0 0 0 1 50 0 440
N 3 0
N 3 0
I 0 0 448 0 0 0 210 1 3 0 0 0 1 48 0 448
N 3 0
N 3 0
C 2a
I 0 0 0 0 0 0 0 0 3 8 0 0 0 44 80000007 0
N 3 8
I 0 0 0 0 0 0 0 0 3 4 0 0 0 0 0 0
N 3 4
I 0 0 0 0 0 0 0 0 1 4 0 0 0 42 80000005 0
N 1 4
I 0 0 0 0 0 0 0 0 0 2 0 0 0 41 80000004 0
N 0 2
C 3f
I 0 0 0 0 0 0 0 0 0 f 0 0 0 47 8000000b 0
N 0 f
I 0 0 0 0 0 0 0 0 1 6 0 0 0 42 80000005 0
N 1 6
I 0 0 0 0 0 0 0 0 0 6 0 0 0 43 80000005 0
N 0 6
I 0 0 0 0 0 0 0 0 3 c 0 0 0 44 80000007 0
N 3 c
I 0 0 0 0 0 0 0 0 1 1 0 0 0 46 8000000b 0
N 1 1
N 3 0
